// ==== Makefile ====
# Verilator build and run for the chip RAM controller

TOP       ?= chipRamTb
SEED      ?= 99
LOG       ?= sim.log
OBJ       ?= obj_dir
VERILATOR ?= verilator
FLIST     ?= sources.f

VFLAGS ?= --binary --timing --assert -GseedInit=$(SEED)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q -e '\*\* FAIL \*\*' -e '%Error' -e 'Assertion failed' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q '\*\* PASS \*\*' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== common/chipRamPkg.sv ====
package chipRamPkg;

    //////////////////////////////
    // SDRAM commands
    //////////////////////////////

    // Bit order is csN, rasN, casN, weN, all active low
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b1111,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVATE  = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_REFRESH   = 4'b0001,
        CMD_MODE      = 4'b0000
    } sdramCmd_t;

    // Who currently owns the SDRAM
    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_CPU,
        OWNER_DMA,
        OWNER_REFRESH
    } accessOwner_t;

    //////////////////////////////
    // Timing and mode constants
    //////////////////////////////

    // Step counters for init and for one access
    typedef logic [3:0] step_t;

    // CAS latency 2, sequential burst of 4
    localparam logic [10:0] MODE_WORD          = 11'h022;
    // A10 high selects all banks
    localparam logic [10:0] PRECHARGE_ALL_ADDR = 11'h400;
    // About 7.8 us at 25 MHz
    localparam logic [7:0]  REFRESH_INTERVAL   = 8'd185;
    localparam step_t       REFRESH_STEPS      = 4'd3;
    localparam step_t       INIT_DONE_STEP     = 4'd13;
    localparam step_t       ACK_STEP           = 4'd5;
    localparam step_t       CPU_END_STEP       = 4'd7;
    localparam step_t       DMA_END_STEP       = 4'd9;

    //////////////////////////////
    // Shared structs
    //////////////////////////////

    // CPU word address plus direction
    typedef struct packed {
        logic [20:1] addr;
        logic        write;
    } cpuReq_t;

    // DMA addresses as Agnus put them on DRA
    typedef struct packed {
        logic [9:0] row;
        logic [9:0] col;
        logic       write;
        // Upper row half, taken from ras0N
        logic       upper;
    } dmaReq_t;

    // Raw Agnus DRAM pins
    typedef struct packed {
        logic       ras0N;
        logic       ras1N;
        logic       casLN;
        logic       casUN;
        logic       dbrN;
        logic       aweN;
        logic [9:0] dra;
    } agnusPins_t;

    // Registered SDRAM control and address pins
    typedef struct packed {
        logic        csN;
        logic        rasN;
        logic        casN;
        logic        weN;
        logic [10:0] addr;
        logic        bank0;
    } sdramPins_t;

endpackage

// ==== logic/agnusSync.sv ====
`timescale 1ns/1ns

module agnusSync import chipRamPkg::*; (
    input  logic       C1,
    input  logic       REFRESH_RST,
    input  agnusPins_t agnusPins,
    output logic       dmaStrobe,
    output dmaReq_t    dmaRequest,
    output logic       dbrFree
);

    // Either strobe low counts as active
    logic rasAnyN;
    logic casAnyN;

    // Two sync flops plus one for edge detection
    logic [2:0] rasSync;
    logic [2:0] casSync;
    logic [1:0] dbrSync;
    logic [1:0] aweSync;

    logic rasFall;
    logic casFall;

    assign rasAnyN = agnusPins.ras0N & agnusPins.ras1N;
    assign casAnyN = agnusPins.casLN & agnusPins.casUN;

    //////////////////////////////
    // Synchronizers
    //////////////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            // All strobes idle high
            rasSync   <= '1;
            casSync   <= '1;
            dbrSync   <= '1;
            aweSync   <= '1;
            dmaStrobe <= 1'b0;
        end else begin
            rasSync   <= {rasSync[1:0], rasAnyN};
            casSync   <= {casSync[1:0], casAnyN};
            dbrSync   <= {dbrSync[0], agnusPins.dbrN};
            aweSync   <= {aweSync[0], agnusPins.aweN};
            // One pulse per Agnus CAS cycle
            dmaStrobe <= casFall;
        end
    end

    assign rasFall = rasSync[2] & ~rasSync[1];
    assign casFall = casSync[2] & ~casSync[1];
    // Agnus not holding the bus
    assign dbrFree = dbrSync[1];

    //////////////////////////////
    // DMA address latches
    //////////////////////////////

    // DRA and ras0N have long settled by the time the synced edge shows up
    always_ff @(posedge C1) begin
        if (rasFall) begin
            dmaRequest.row   <= agnusPins.dra;
            // 8372A mapping, ras0 active means upper half
            dmaRequest.upper <= ~agnusPins.ras0N;
        end
        if (casFall) begin
            dmaRequest.col   <= agnusPins.dra;
            dmaRequest.write <= ~aweSync[1];
        end
    end

endmodule

// ==== logic/chipRamCtrl.sv ====
`timescale 1ns/1ns

module chipRamCtrl import chipRamPkg::*; (
    input  logic       C1,
    input  logic       REFRESH_RST,
    input  logic       cpuReq,
    input  cpuReq_t    cpuRequest,
    input  logic       twoMbEn,
    input  agnusPins_t agnusPins,
    output logic       cpuAck,
    output sdramPins_t sdram,
    output logic       dmaCycle,
    output logic       dbEnN,
    output logic       initDone
);

    // Refresh handshake
    logic refreshDue;
    logic refreshIssued;

    // Agnus side
    logic    dmaStrobe;
    dmaReq_t dmaRequest;
    logic    dbrFree;

    // Slots toward the sequencer
    logic    cpuSlotReq;
    logic    cpuSlotAck;
    cpuReq_t cpuSlotData;
    logic    dmaSlotReq;
    logic    dmaSlotAck;
    dmaReq_t dmaSlotData;

    sdramCmd_t    cmd;
    accessOwner_t owner;

    //////////////////////////////
    // Request sources
    //////////////////////////////

    refreshTimer refreshTimer_i (
        .C1            (C1),
        .REFRESH_RST   (REFRESH_RST),
        .refreshIssued (refreshIssued),
        .refreshDue    (refreshDue)
    );

    agnusSync agnusSync_i (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .agnusPins   (agnusPins),
        .dmaStrobe   (dmaStrobe),
        .dmaRequest  (dmaRequest),
        .dbrFree     (dbrFree)
    );

    // External four-phase port passes through
    requestSlot #(.payload_t(cpuReq_t)) cpuSlot (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .inReq       (cpuReq),
        .inData      (cpuRequest),
        .slotAck     (cpuSlotAck),
        .slotReq     (cpuSlotReq),
        .slotData    (cpuSlotData),
        .inAck       (cpuAck)
    );

    // Strobe becomes a held request, Agnus never sees an ack
    requestSlot #(.payload_t(dmaReq_t)) dmaSlot (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .inReq       (dmaStrobe),
        .inData      (dmaRequest),
        .slotAck     (dmaSlotAck),
        .slotReq     (dmaSlotReq),
        .slotData    (dmaSlotData),
        .inAck       ()
    );

    //////////////////////////////
    // SDRAM control
    //////////////////////////////

    sdramSequencer sdramSequencer_i (
        .C1            (C1),
        .REFRESH_RST   (REFRESH_RST),
        .refreshDue    (refreshDue),
        .dbrFree       (dbrFree),
        .cpuSlotReq    (cpuSlotReq),
        .dmaSlotReq    (dmaSlotReq),
        .cpuWrite      (cpuSlotData.write),
        .dmaWrite      (dmaSlotData.write),
        .dmaCol0       (dmaSlotData.col[0]),
        .cmd           (cmd),
        .owner         (owner),
        .cpuSlotAck    (cpuSlotAck),
        .dmaSlotAck    (dmaSlotAck),
        .refreshIssued (refreshIssued),
        .dmaCycle      (dmaCycle),
        .dbEnN         (dbEnN),
        .initDone      (initDone)
    );

    sdramAddrMux sdramAddrMux_i (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .cmd         (cmd),
        .owner       (owner),
        .cpuRequest  (cpuSlotData),
        .dmaRequest  (dmaSlotData),
        .twoMbEn     (twoMbEn),
        .sdram       (sdram)
    );

endmodule

// ==== logic/refreshTimer.sv ====
`timescale 1ns/1ns

module refreshTimer import chipRamPkg::*; (
    input  logic C1,
    input  logic REFRESH_RST,
    input  logic refreshIssued,
    output logic refreshDue
);

    // Cycles since the last auto-refresh
    logic [7:0] refreshCount;

    //////////////////////////////
    // Saturating counter
    //////////////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            refreshCount <= '0;
        end else if (refreshIssued) begin
            // Sequencer has just taken the refresh slot
            refreshCount <= '0;
        end else if (refreshCount != REFRESH_INTERVAL) begin
            refreshCount <= refreshCount + 8'd1;
        end
    end

    // Stays high until the sequencer gets round to it
    assign refreshDue = (refreshCount == REFRESH_INTERVAL);

endmodule

// ==== logic/requestSlot.sv ====
`timescale 1ns/1ns

module requestSlot #(
    parameter type payload_t = logic
) (
    input  logic     C1,
    input  logic     REFRESH_RST,
    input  logic     inReq,
    input  payload_t inData,
    input  logic     slotAck,
    output logic     slotReq,
    output payload_t slotData,
    output logic     inAck
);

    // Idle, waiting on the sequencer, then waiting for the requester to let go
    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_PENDING,
        SLOT_DONE
    } slotState_t;

    slotState_t state;

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            state <= SLOT_IDLE;
        end else begin
            case (state)
                SLOT_IDLE: begin
                    if (inReq) begin
                        state <= SLOT_PENDING;
                    end
                end
                SLOT_PENDING: begin
                    // Access finished in the sequencer
                    if (slotAck) begin
                        state <= SLOT_DONE;
                    end
                end
                default: begin
                    if (!inReq) begin
                        state <= SLOT_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload captured at the start of a request
    always_ff @(posedge C1) begin
        if (state == SLOT_IDLE && inReq) begin
            slotData <= inData;
        end
    end

    assign slotReq = (state == SLOT_PENDING);
    // Ack passes straight through, then holds until inReq drops
    assign inAck   = (state == SLOT_DONE) || (slotReq && slotAck);

endmodule

// ==== sdramSeq/sdramAddrMux.sv ====
`timescale 1ns/1ns

module sdramAddrMux import chipRamPkg::*; (
    input  logic         C1,
    input  logic         REFRESH_RST,
    input  sdramCmd_t    cmd,
    input  accessOwner_t owner,
    input  cpuReq_t      cpuRequest,
    input  dmaReq_t      dmaRequest,
    input  logic         twoMbEn,
    output sdramPins_t   sdram
);

    logic [10:0] nextAddr;
    logic        cpuOwned;

    assign cpuOwned = (owner == OWNER_CPU);

    // Row and column layout per command
    always_comb begin
        nextAddr = '0;
        case (cmd)
            CMD_PRECHARGE: nextAddr = PRECHARGE_ALL_ADDR;
            CMD_MODE:      nextAddr = MODE_WORD;
            CMD_ACTIVATE: begin
                if (cpuOwned) begin
                    nextAddr = {1'b0, cpuRequest.addr[19], cpuRequest.addr[17:9]};
                end else begin
                    // 8372A row, RAS0 picks the half
                    nextAddr = {1'b0, dmaRequest.upper, dmaRequest.row[8:0]};
                end
            end
            CMD_READ, CMD_WRITE: begin
                if (cpuOwned) begin
                    nextAddr = {3'b000, cpuRequest.addr[18], cpuRequest.addr[8:2]};
                end else begin
                    nextAddr = {3'b000, dmaRequest.col[8:1]};
                end
            end
            default: nextAddr = '0;
        endcase
    end

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            // NOP with the bus parked
            sdram <= '{csN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1,
                       addr: '0, bank0: 1'b0};
        end else begin
            {sdram.csN, sdram.rasN, sdram.casN, sdram.weN} <= cmd;
            sdram.addr  <= nextAddr;
            // Second megabyte only for CPU accesses
            sdram.bank0 <= cpuOwned && twoMbEn && cpuRequest.addr[20];
        end
    end

endmodule

// ==== sdramSeq/sdramSequencer.sv ====
`timescale 1ns/1ns

module sdramSequencer import chipRamPkg::*; (
    input  logic         C1,
    input  logic         REFRESH_RST,
    input  logic         refreshDue,
    input  logic         dbrFree,
    input  logic         cpuSlotReq,
    input  logic         dmaSlotReq,
    input  logic         cpuWrite,
    input  logic         dmaWrite,
    input  logic         dmaCol0,
    output sdramCmd_t    cmd,
    output accessOwner_t owner,
    output logic         cpuSlotAck,
    output logic         dmaSlotAck,
    output logic         refreshIssued,
    output logic         dmaCycle,
    output logic         dbEnN,
    output logic         initDone
);

    step_t initStep;
    step_t step;
    step_t endStep;

    logic idle;
    logic dmaPending;
    logic cpuPending;
    logic grantDma;
    logic grantCpu;
    logic accessWrite;

    //////////////////////////////
    // Arbitration
    //////////////////////////////

    assign idle       = initDone && (owner == OWNER_NONE);
    // Ack still high means the slot has not let go yet
    assign dmaPending = dmaSlotReq && !dmaSlotAck;
    assign cpuPending = cpuSlotReq && !cpuSlotAck;

    // Refresh first, then DMA, then CPU
    assign refreshIssued = idle && refreshDue;
    assign grantDma      = idle && !refreshDue && dmaPending;
    // CPU only while Agnus leaves the bus alone
    assign grantCpu      = idle && !refreshDue && !dmaPending && cpuPending && dbrFree;

    // Last step of the current access
    always_comb begin
        case (owner)
            OWNER_CPU: endStep = CPU_END_STEP;
            OWNER_DMA: endStep = DMA_END_STEP;
            default:   endStep = REFRESH_STEPS;
        endcase
    end

    assign accessWrite = (owner == OWNER_CPU) ? cpuWrite : dmaWrite;

    //////////////////////////////
    // Step counters
    //////////////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            initStep   <= '0;
            initDone   <= 1'b0;
            step       <= '0;
            owner      <= OWNER_NONE;
            cpuSlotAck <= 1'b0;
            dmaSlotAck <= 1'b0;
            dmaCycle   <= 1'b0;
            dbEnN      <= 1'b1;
        end else begin
            // Power-up sequence, counts once and stops
            if (!initDone) begin
                if (initStep == INIT_DONE_STEP) begin
                    initDone <= 1'b1;
                end else begin
                    initStep <= initStep + 4'd1;
                end
            end

            if (refreshIssued) begin
                owner <= OWNER_REFRESH;
                step  <= '0;
            end else if (grantDma) begin
                owner <= OWNER_DMA;
                step  <= '0;
            end else if (grantCpu) begin
                owner <= OWNER_CPU;
                step  <= '0;
            end else if (owner != OWNER_NONE) begin
                if (step == endStep) begin
                    owner <= OWNER_NONE;
                    step  <= '0;
                end else begin
                    step <= step + 4'd1;
                end
            end

            // CPU ack rises mid-access and falls once the slot drops its request
            if (owner == OWNER_CPU && step == ACK_STEP) begin
                cpuSlotAck <= 1'b1;
            end else if (cpuSlotAck && !cpuSlotReq) begin
                cpuSlotAck <= 1'b0;
            end

            // DMA request is held until the whole access is over
            if (owner == OWNER_DMA && step == DMA_END_STEP) begin
                dmaSlotAck <= 1'b1;
            end else if (dmaSlotAck && !dmaSlotReq) begin
                dmaSlotAck <= 1'b0;
            end

            // Registered like the SDRAM pins so both line up
            dmaCycle <= (owner == OWNER_DMA);
            // Buffer enable follows DRA0 of the column
            dbEnN    <= !((owner == OWNER_DMA) && dmaCol0);
        end
    end

    //////////////////////////////
    // Command decode
    //////////////////////////////

    always_comb begin
        cmd = CMD_NOP;
        if (!initDone) begin
            case (initStep)
                4'd0:       cmd = CMD_PRECHARGE;
                4'd2:       cmd = CMD_MODE;
                4'd5, 4'd9: cmd = CMD_REFRESH;
                default:    cmd = CMD_NOP;
            endcase
        end else if (owner == OWNER_REFRESH) begin
            if (step == '0) begin
                cmd = CMD_REFRESH;
            end
        end else if (owner != OWNER_NONE) begin
            case (step)
                4'd0:    cmd = CMD_ACTIVATE;
                // RAS to CAS delay covered by step 1
                4'd2:    cmd = accessWrite ? CMD_WRITE : CMD_READ;
                4'd3:    cmd = CMD_PRECHARGE;
                default: cmd = CMD_NOP;
            endcase
        end
    end

endmodule

// ==== sources.f ====
common/chipRamPkg.sv
logic/refreshTimer.sv
logic/requestSlot.sv
logic/agnusSync.sv
sdramSeq/sdramSequencer.sv
sdramSeq/sdramAddrMux.sv
logic/chipRamCtrl.sv
tests/chipRam_assert.sv
tests/chipRamTb.sv

// ==== tests/chipRamTb.sv ====
`timescale 1ns/1ns

module chipRamTb import chipRamPkg::*; #(
    parameter int seedInit = 99
);

    logic       C1;
    logic       REFRESH_RST;
    logic       cpuReq;
    cpuReq_t    cpuRequest;
    logic       twoMbEn;
    agnusPins_t agnusPins;
    logic       cpuAck;
    sdramPins_t sdram;
    logic       dmaCycle;
    logic       dbEnN;
    logic       initDone;

    integer seed;
    int     valueErrors = 0;
    int     timeoutErrors = 0;
    int     totalErrors;

    // Expected DMA request, set by the Agnus task
    logic [9:0] expRow;
    logic [9:0] expCol;
    logic       expUpper;
    logic       expDmaWrite;

    // Monitor state
    sdramCmd_t busCmd;
    logic      lastActDma;
    logic      prevAck;
    logic      prevInit;
    logic      expectDmaFirst;
    int        sinceAct;
    int        actAge;
    int        dmaLen;
    logic      sawPre;
    logic      sawMode;
    int        initRefreshes;
    int        laterRefreshes;

    chipRamCtrl chipRamCtrl_i (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .cpuReq      (cpuReq),
        .cpuRequest  (cpuRequest),
        .twoMbEn     (twoMbEn),
        .agnusPins   (agnusPins),
        .cpuAck      (cpuAck),
        .sdram       (sdram),
        .dmaCycle    (dmaCycle),
        .dbEnN       (dbEnN),
        .initDone    (initDone)
    );

    // 20 ns clock
    always #10 C1 = ~C1;

    assign busCmd = sdramCmd_t'({sdram.csN, sdram.rasN, sdram.casN, sdram.weN});

    task automatic checkAddr(input string name, input logic [10:0] got, input logic [10:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////
    // Bus monitor
    //////////////////////////////

    // Pins are registered, mid-cycle is stable
    always @(negedge C1) begin
        if (!REFRESH_RST) begin
            if (!initDone) begin
                if (busCmd == CMD_PRECHARGE) begin
                    sawPre = 1'b1;
                    checkAddr("sdram.addr", sdram.addr, 11'h400);
                end
                if (busCmd == CMD_MODE) begin
                    sawMode = 1'b1;
                    checkAddr("sdram.addr", sdram.addr, 11'h022);
                    if (!sawPre) begin
                        valueErrors++;
                        $display("MODE issued before PRECHARGE during init");
                    end
                end
                if (busCmd == CMD_REFRESH) begin
                    initRefreshes++;
                    if (!sawMode) begin
                        valueErrors++;
                        $display("Init REFRESH issued before MODE");
                    end
                end
            end else if (busCmd == CMD_REFRESH) begin
                laterRefreshes++;
            end
            // First cycle after init
            if (initDone && !prevInit) begin
                if (!sawPre || !sawMode || initRefreshes != 2) begin
                    valueErrors++;
                    $display("Init sequence incomplete before initDone");
                end
            end
            sinceAct++;
            actAge++;
            if (busCmd == CMD_ACTIVATE) begin
                actAge = 0;
                lastActDma = dmaCycle;
                if (expectDmaFirst && !dmaCycle) begin
                    valueErrors++;
                    $display("CPU access went ahead of a pending DMA access");
                end
                expectDmaFirst = 1'b0;
                if (dmaCycle) begin
                    checkAddr("sdram.addr", sdram.addr, {1'b0, expUpper, expRow[8:0]});
                    if (dbEnN !== ~expCol[0]) begin
                        valueErrors++;
                        $display("Fail dbEnN: got %h expected %h", dbEnN, ~expCol[0]);
                    end
                end else begin
                    sinceAct = 0;
                    checkAddr("sdram.addr", sdram.addr,
                              {1'b0, cpuRequest.addr[19], cpuRequest.addr[17:9]});
                    if (sdram.bank0 !== (twoMbEn & cpuRequest.addr[20])) begin
                        valueErrors++;
                        $display("Fail sdram.bank0: got %h expected %h",
                                 sdram.bank0, twoMbEn & cpuRequest.addr[20]);
                    end
                end
            end
            if (busCmd == CMD_READ || busCmd == CMD_WRITE) begin
                // Column command two cycles after the row opens
                if (actAge != 2) begin
                    valueErrors++;
                    $display("Fail READ/WRITE delay: got %h expected %h", actAge, 2);
                end
                if (lastActDma) begin
                    checkAddr("sdram.addr", sdram.addr, {3'b000, expCol[8:1]});
                    checkAddr("sdram.weN", {10'd0, sdram.weN}, {10'd0, ~expDmaWrite});
                end else begin
                    checkAddr("sdram.addr", sdram.addr,
                              {3'b000, cpuRequest.addr[18], cpuRequest.addr[8:2]});
                    checkAddr("sdram.weN", {10'd0, sdram.weN}, {10'd0, ~cpuRequest.write});
                end
            end
            // Row closes right after the column command
            if (initDone && busCmd == CMD_PRECHARGE && actAge != 3) begin
                valueErrors++;
                $display("Fail PRECHARGE delay: got %h expected %h", actAge, 3);
            end
            // DMA window spans steps 0 to DMA_END_STEP
            if (dmaCycle) begin
                dmaLen++;
            end else if (dmaLen != 0) begin
                if (dmaLen != DMA_END_STEP + 1) begin
                    valueErrors++;
                    $display("Fail dmaCycle length: got %h expected %h",
                             dmaLen, DMA_END_STEP + 1);
                end
                dmaLen = 0;
            end
            if (cpuAck && !prevAck && sinceAct != 5) begin
                valueErrors++;
                $display("Fail cpuAck delay: got %h expected %h", sinceAct, 5);
            end
            prevAck  = cpuAck;
            prevInit = initDone;
        end
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    // 0 is cpuAck, 1 is dmaCycle, 2 is initDone
    task automatic waitSignal(input int which, input logic level, input int limit);
        int   count;
        logic value;
        count = 0;
        value = ~level;
        while (value !== level && count < limit) begin
            @(negedge C1);
            count++;
            case (which)
                0:       value = cpuAck;
                1:       value = dmaCycle;
                default: value = initDone;
            endcase
        end
        if (value !== level) begin
            timeoutErrors++;
            $display("Timed out waiting for signal %0d to reach %0d", which, level);
        end
    endtask

    task automatic cpuStart();
        logic [31:0] rnd;
        @(negedge C1);
        rnd              = $random(seed);
        cpuRequest.addr  = rnd[19:0];
        rnd              = $random(seed);
        cpuRequest.write = rnd[0];
        rnd              = $random(seed);
        twoMbEn          = rnd[0];
        cpuReq           = 1'b1;
    endtask

    task automatic cpuFinish();
        waitSignal(0, 1'b1, 60);
        @(negedge C1);
        cpuReq = 1'b0;
        waitSignal(0, 1'b0, 10);
    endtask

    // RAS with the row, then CAS with the column, optionally freeing DBR late
    task automatic agnusAccess(input logic [9:0] row, input logic [9:0] col,
                               input logic upper, input logic write, input logic lateDbr);
        expRow      = row;
        expCol      = col;
        expUpper    = upper;
        expDmaWrite = write;
        @(negedge C1);
        agnusPins.dra   = row;
        agnusPins.ras0N = ~upper;
        agnusPins.ras1N = upper;
        agnusPins.aweN  = ~write;
        repeat (5) @(negedge C1);
        agnusPins.dra   = col;
        agnusPins.casLN = 1'b0;
        if (lateDbr) begin
            // Synced DBR frees in the same cycle the DMA slot fills
            repeat (2) @(negedge C1);
            agnusPins.dbrN = 1'b1;
        end
        repeat (4) @(negedge C1);
        agnusPins.ras0N = 1'b1;
        agnusPins.ras1N = 1'b1;
        agnusPins.casLN = 1'b1;
        agnusPins.aweN  = 1'b1;
        waitSignal(1, 1'b1, 40);
        waitSignal(1, 1'b0, 40);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        seed = seedInit;
        C1 = 1'b0;
        REFRESH_RST = 1'b1;
        cpuReq = 1'b0;
        cpuRequest = '0;
        twoMbEn = 1'b0;
        agnusPins = '{ras0N: 1'b1, ras1N: 1'b1, casLN: 1'b1, casUN: 1'b1,
                      dbrN: 1'b1, aweN: 1'b1, dra: '0};
        lastActDma = 1'b0;
        prevAck = 1'b0;
        prevInit = 1'b0;
        expectDmaFirst = 1'b0;
        sinceAct = 0;
        actAge = 0;
        dmaLen = 0;
        sawPre = 1'b0;
        sawMode = 1'b0;
        initRefreshes = 0;
        laterRefreshes = 0;
        expRow = '0;
        expCol = '0;
        expUpper = 1'b0;
        expDmaWrite = 1'b0;
        repeat (5) @(negedge C1);
        REFRESH_RST = 1'b0;
        waitSignal(2, 1'b1, 40);

        // Random CPU accesses
        repeat (6) begin
            cpuStart();
            cpuFinish();
        end

        // Agnus holds the bus, CPU must wait
        @(negedge C1);
        agnusPins.dbrN = 1'b0;
        cpuStart();
        repeat (12) @(negedge C1);
        if (cpuAck !== 1'b0) begin
            valueErrors++;
            $display("Fail cpuAck: got %h expected %h", cpuAck, 1'b0);
        end
        agnusPins.dbrN = 1'b1;
        cpuFinish();

        // Plain DMA accesses, both halves and both directions
        agnusAccess(10'h155, 10'h0a3, 1'b1, 1'b0, 1'b0);
        agnusAccess(10'h2ea, 10'h35c, 1'b0, 1'b1, 1'b0);

        // CPU and DMA pending together, DMA wins
        @(negedge C1);
        agnusPins.dbrN = 1'b0;
        cpuStart();
        expectDmaFirst = 1'b1;
        agnusAccess(10'h0f0, 10'h10f, 1'b1, 1'b1, 1'b1);
        cpuFinish();

        // Steady CPU traffic across several refresh intervals
        laterRefreshes = 0;
        repeat (50) begin
            cpuStart();
            cpuFinish();
        end
        if (laterRefreshes < 2) begin
            valueErrors++;
            $display("Refresh did not run during CPU traffic");
        end

        repeat (5) @(negedge C1);
        totalErrors = valueErrors + timeoutErrors + chipRamCtrl_i.chipRamAssert_i.assertErrors;
        $display("errors: value %0d timeout %0d assertion %0d", valueErrors, timeoutErrors,
                 chipRamCtrl_i.chipRamAssert_i.assertErrors);
        if (totalErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tests/chipRam_assert.sv ====
`timescale 1ns/1ns

module chipRamAssert import chipRamPkg::*; (
    input logic       C1,
    input logic       REFRESH_RST,
    input logic       cpuReq,
    input logic       cpuAck,
    input sdramPins_t sdram,
    input logic       dmaCycle,
    input logic       initDone,
    input logic       dbrFree
);

    // Longest gap between two refreshes, a DMA access can sit in front of one
    localparam int REFRESH_GAP_MAX = REFRESH_INTERVAL + DMA_END_STEP + 2;

    sdramCmd_t busCmd;
    logic      isAct;
    logic      isCpuAct;
    logic      isRef;

    // Cycles since the last REFRESH on the bus
    int   refreshGap;
    logic refreshSeen;

    // Read by the testbench for its closing count
    int assertErrors = 0;

    assign busCmd   = sdramCmd_t'({sdram.csN, sdram.rasN, sdram.casN, sdram.weN});
    assign isAct    = (busCmd == CMD_ACTIVATE);
    // dmaCycle is registered alongside the pins
    assign isCpuAct = isAct && !dmaCycle;
    assign isRef    = (busCmd == CMD_REFRESH);

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            refreshGap  <= 0;
            refreshSeen <= 1'b0;
        end else if (isRef) begin
            refreshGap  <= 1;
            refreshSeen <= 1'b1;
        end else if (refreshGap < 1000) begin
            refreshGap <= refreshGap + 1;
        end
    end

    //////////////////////////////
    // Init and access order
    //////////////////////////////

    // No row opened before the power-up sequence is over
    actAfterInit: assert property (@(posedge C1) disable iff (REFRESH_RST)
        isAct |-> initDone)
        else begin
            assertErrors++;
            $error("ACTIVATE issued before initialization finished");
        end

    // Ack five cycles after the row opens
    ackTiming: assert property (@(posedge C1) disable iff (REFRESH_RST)
        isCpuAct |-> ##5 $rose(cpuAck))
        else begin
            assertErrors++;
            $error("cpuAck did not rise five cycles after CPU ACTIVATE");
        end

    // Four-phase, ack drops only once req has gone
    ackFall: assert property (@(posedge C1) disable iff (REFRESH_RST)
        $fell(cpuAck) |-> !$past(cpuReq))
        else begin
            assertErrors++;
            $error("cpuAck fell while cpuReq was still high");
        end

    // Grant sampled dbrFree two cycles before the pins show ACTIVATE
    dbrHold: assert property (@(posedge C1) disable iff (REFRESH_RST)
        isCpuAct |-> $past(dbrFree, 2))
        else begin
            assertErrors++;
            $error("CPU ACTIVATE while Agnus held the bus");
        end

    //////////////////////////////
    // Refresh
    //////////////////////////////

    // NOP, READ/WRITE, PRECHARGE follow the ACTIVATE
    noRefreshInAccess: assert property (@(posedge C1) disable iff (REFRESH_RST)
        isAct |=> !isRef [*3])
        else begin
            assertErrors++;
            $error("REFRESH inside an open row");
        end

    refreshInterval: assert property (@(posedge C1) disable iff (REFRESH_RST)
        (initDone && refreshSeen) |-> (refreshGap <= REFRESH_GAP_MAX))
        else begin
            assertErrors++;
            $error("Refresh interval exceeded");
        end

endmodule

bind chipRamCtrl chipRamAssert chipRamAssert_i (
    .C1          (C1),
    .REFRESH_RST (REFRESH_RST),
    .cpuReq      (cpuReq),
    .cpuAck      (cpuAck),
    .sdram       (sdram),
    .dmaCycle    (dmaCycle),
    .initDone    (initDone),
    .dbrFree     (dbrFree)
);
